// File: logic/icache_defines.svh
// #########################################################################
// Instruction cache geometry
// Fetch width, PC and field widths, line size and line count
// #########################################################################

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Instructions handed to the decoder per fetch
`define ICACHE_FETCH_WIDTH 2

// Program counter width, in instructions
`define ICACHE_PC_WIDTH 8

// Warps per compute unit
`define ICACHE_NUM_WARPS 8

// Threads per warp, one active mask bit each
`define ICACHE_WARP_WIDTH 32

// Encoded instruction width
`define ICACHE_ENC_INST_WIDTH 4

// Log2 of instructions per line, also the memory interface width
`define ICACHE_LINE_IDX_BITS 2

// Number of cachelines, direct mapped
`define ICACHE_NUM_LINES 8

`endif

// File: logic/icache_pkg.sv
// #########################################################################
// Instruction cache package
// Derived widths and the types shared by the cache blocks
// #########################################################################

`include "icache_defines.svh"

package icache_pkg;

    // Derived geometry
    // PC = {tag, line select, line offset}
    localparam int unsigned LineInsts     = 1 << `ICACHE_LINE_IDX_BITS;
    localparam int unsigned LineSelBits   = $clog2(`ICACHE_NUM_LINES);
    localparam int unsigned TagBits       = `ICACHE_PC_WIDTH - `ICACHE_LINE_IDX_BITS
                                            - LineSelBits;
    localparam int unsigned LineAddrBits  = `ICACHE_PC_WIDTH - `ICACHE_LINE_IDX_BITS;
    localparam int unsigned WidBits       = $clog2(`ICACHE_NUM_WARPS);
    localparam int unsigned SubwarpIdBits = $clog2(`ICACHE_WARP_WIDTH);

    // Request metadata
    typedef logic [`ICACHE_PC_WIDTH-1:0]    pc_t;
    typedef logic [WidBits-1:0]             wid_t;
    typedef logic [SubwarpIdBits-1:0]       subwarp_id_t;
    typedef logic [`ICACHE_WARP_WIDTH-1:0]  act_mask_t;

    // Instructions, one bit or one entry per fetch slot
    typedef logic [`ICACHE_ENC_INST_WIDTH-1:0]        enc_inst_t;
    typedef logic [`ICACHE_FETCH_WIDTH-1:0]           fetch_mask_t;
    typedef enc_inst_t [`ICACHE_FETCH_WIDTH-1:0]      fetch_insts_t;

    // Cacheline and its addressing
    typedef enc_inst_t [LineInsts-1:0]          line_t;
    typedef logic [LineAddrBits-1:0]            line_addr_t;
    typedef logic [LineSelBits-1:0]             line_sel_t;
    typedef logic [TagBits-1:0]                 tag_t;
    typedef logic [`ICACHE_LINE_IDX_BITS-1:0]   line_off_t;

endpackage : icache_pkg

// File: logic/icache_sram.sv
// #########################################################################
// Single-port synchronous memory
// Registered read port, one word type per instance
// #########################################################################

`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_sram
    import icache_pkg::*;
#(
    // Stored word, a tag or a full line
    parameter type         word_t   = logic,
    parameter int unsigned NumWords = `ICACHE_NUM_LINES
) (
    input  logic      clk_i,
    input  logic      rst_ni,

    // Access port
    input  logic      req_i,
    input  logic      we_i,
    input  line_sel_t addr_i,
    input  word_t     wdata_i,
    output word_t     rdata_o
);

    // Storage array
    word_t mem_q [NumWords];

    // Read data register
    word_t rdata_q;

    // Write updates the word at the edge
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // Read data valid one cycle after an enabled read
    // Holds its value while no read is issued
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (req_i && !we_i) begin
            rdata_q <= mem_q[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule : icache_sram

// File: logic/icache_line_extract.sv
// #########################################################################
// Line extractor
// Picks the fetch slots out of a cacheline, clipped at the line end
// #########################################################################

`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_line_extract
    import icache_pkg::*;
(
    // Source line and the request it serves
    input  line_t        line_i,
    input  pc_t          pc_i,
    input  fetch_mask_t  fetch_mask_i,

    // One valid bit and one instruction per slot
    output fetch_mask_t  valid_o,
    output fetch_insts_t inst_o
);

    // Offset of slot 0 within the line
    line_off_t line_off;

    assign line_off = pc_i[`ICACHE_LINE_IDX_BITS-1:0];

    // #########################################################################
    // Slot selection
    // #########################################################################

    always_comb begin
        // Slots past the line end stay zero
        valid_o = '0;
        inst_o  = '0;

        for (int k = 0; k < `ICACHE_FETCH_WIDTH; k++) begin
            // Slot k reads line entry offset + k
            if ((int'(line_off) + k) < LineInsts) begin
                valid_o[k] = fetch_mask_i[k];
                inst_o[k]  = line_i[line_off + line_off_t'(k)];
            end
        end
    end

endmodule : icache_line_extract

// File: logic/icache_ctrl.sv
// #########################################################################
// Instruction cache controller
// Lookup FSM, hit/miss decision, refill, flush and decoder handshake
// #########################################################################

`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,

    // Fetcher
    input  logic         fe_valid_i,
    input  pc_t          fe_pc_i,
    input  fetch_mask_t  fe_fetch_mask_i,
    input  act_mask_t    fe_act_mask_i,
    input  wid_t         fe_warp_id_i,
    input  subwarp_id_t  fe_subwarp_id_i,
    output logic         ic_ready_o,

    // Backing memory
    input  logic         mem_ready_i,
    output logic         mem_req_o,
    output line_addr_t   mem_addr_o,
    input  logic         mem_valid_i,
    input  line_t        mem_data_i,

    // Tag and line memories
    output logic         ram_req_o,
    output logic         ram_we_o,
    output line_sel_t    ram_sel_o,
    output tag_t         tag_wdata_o,
    input  tag_t         tag_rdata_i,

    // Hit and refill extractors
    output pc_t          req_pc_o,
    output fetch_mask_t  req_fetch_mask_o,
    output line_t        fill_line_o,
    input  fetch_mask_t  hit_valid_i,
    input  fetch_insts_t hit_inst_i,
    input  fetch_mask_t  fill_valid_i,
    input  fetch_insts_t fill_inst_i,

    // Decoder
    input  logic         dec_ready_i,
    output fetch_mask_t  ic_valid_o,
    output fetch_insts_t ic_inst_o,
    output pc_t          ic_pc_o,
    output fetch_mask_t  ic_fetch_mask_o,
    output act_mask_t    ic_act_mask_o,
    output wid_t         ic_warp_id_o,
    output subwarp_id_t  ic_subwarp_id_o
);

    // #########################################################################
    // Signals
    // #########################################################################

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOOKUP   = 2'd1,
        WAIT_MEM = 2'd2,
        WAIT_DEC = 2'd3
    } state_e;

    state_e state_q, state_d;

    // Flush latch and per-line valid bits
    logic                         flush_q, flush_d;
    logic [`ICACHE_NUM_LINES-1:0] line_valid_q, line_valid_d;

    // Valid bit of the line looked up, aligned with the tag read
    logic look_valid_q, look_valid_d;

    // Held request, loaded on acceptance
    logic        req_load;
    pc_t         req_pc_q;
    fetch_mask_t req_fetch_mask_q;
    act_mask_t   req_act_mask_q;
    wid_t        req_warp_id_q;
    subwarp_id_t req_subwarp_id_q;

    // Refill buffer
    logic  fill_load;
    line_t fill_line_q;

    line_sel_t fe_sel, req_sel;
    tag_t      req_tag;
    logic      hit;
    logic      out_hit, out_fill;

    // PC fields, {tag, select, offset}
    assign fe_sel  = fe_pc_i[LineSelBits+`ICACHE_LINE_IDX_BITS-1:`ICACHE_LINE_IDX_BITS];
    assign req_sel = req_pc_q[LineSelBits+`ICACHE_LINE_IDX_BITS-1:`ICACHE_LINE_IDX_BITS];
    assign req_tag = req_pc_q[`ICACHE_PC_WIDTH-1-:TagBits];

    assign hit = look_valid_q && (tag_rdata_i == req_tag);

    // Tag written on refill comes from the held PC
    assign tag_wdata_o      = req_tag;
    assign req_pc_o         = req_pc_q;
    assign req_fetch_mask_o = req_fetch_mask_q;
    assign fill_line_o      = fill_line_q;

    // #########################################################################
    // State machine
    // #########################################################################

    always_comb begin
        state_d      = state_q;
        flush_d      = flush_q | flush_i;
        line_valid_d = line_valid_q;
        look_valid_d = look_valid_q;
        req_load     = 1'b0;
        fill_load    = 1'b0;

        ic_ready_o = 1'b0;
        mem_req_o  = 1'b0;
        mem_addr_o = '0;
        ram_req_o  = 1'b0;
        ram_we_o   = 1'b0;
        ram_sel_o  = '0;

        case (state_q)
            IDLE: begin
                ic_ready_o = 1'b1;
            end
            LOOKUP: begin
                if (hit) begin
                    // Hit data is on the decoder outputs
                    if (dec_ready_i) begin
                        ic_ready_o = 1'b1;
                        state_d    = IDLE;
                    end
                end else begin
                    // Miss, request the whole line
                    mem_req_o  = 1'b1;
                    mem_addr_o = req_pc_q[`ICACHE_PC_WIDTH-1:`ICACHE_LINE_IDX_BITS];
                    if (mem_ready_i) begin
                        state_d = WAIT_MEM;
                    end
                end
            end
            WAIT_MEM: begin
                // Write tag and line, keep a copy for delivery
                if (mem_valid_i) begin
                    ram_req_o             = 1'b1;
                    ram_we_o              = 1'b1;
                    ram_sel_o             = req_sel;
                    line_valid_d[req_sel] = 1'b1;
                    fill_load             = 1'b1;
                    state_d               = WAIT_DEC;
                end
            end
            WAIT_DEC: begin
                if (dec_ready_i) begin
                    ic_ready_o = 1'b1;
                    state_d    = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // Pending flush takes the idle cycle or the handshake
        if (ic_ready_o && flush_q) begin
            ic_ready_o   = 1'b0;
            line_valid_d = '0;
            flush_d      = flush_i;
        end else if (ic_ready_o && fe_valid_i) begin
            // Accept and start the lookup in both memories
            state_d      = LOOKUP;
            req_load     = 1'b1;
            ram_req_o    = 1'b1;
            ram_sel_o    = fe_sel;
            look_valid_d = line_valid_q[fe_sel];
        end
    end

    // #########################################################################
    // Decoder outputs
    // #########################################################################

    assign out_hit  = (state_q == LOOKUP) && hit;
    assign out_fill = (state_q == WAIT_DEC);

    always_comb begin
        ic_valid_o      = '0;
        ic_inst_o       = '0;
        ic_pc_o         = '0;
        ic_fetch_mask_o = '0;
        ic_act_mask_o   = '0;
        ic_warp_id_o    = '0;
        ic_subwarp_id_o = '0;

        if (out_hit) begin
            ic_valid_o = hit_valid_i;
            ic_inst_o  = hit_inst_i;
        end else if (out_fill) begin
            ic_valid_o = fill_valid_i;
            ic_inst_o  = fill_inst_i;
        end

        // Metadata passes through from the held request
        if (out_hit || out_fill) begin
            ic_pc_o         = req_pc_q;
            ic_fetch_mask_o = req_fetch_mask_q;
            ic_act_mask_o   = req_act_mask_q;
            ic_warp_id_o    = req_warp_id_q;
            ic_subwarp_id_o = req_subwarp_id_q;
        end
    end

    // #########################################################################
    // Registers
    // #########################################################################

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            flush_q      <= 1'b0;
            line_valid_q <= '0;
            look_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            flush_q      <= flush_d;
            line_valid_q <= line_valid_d;
            look_valid_q <= look_valid_d;
        end
    end

    // Request payload and refill buffer
    always_ff @(posedge clk_i) begin
        if (req_load) begin
            req_pc_q         <= fe_pc_i;
            req_fetch_mask_q <= fe_fetch_mask_i;
            req_act_mask_q   <= fe_act_mask_i;
            req_warp_id_q    <= fe_warp_id_i;
            req_subwarp_id_q <= fe_subwarp_id_i;
        end
        if (fill_load) begin
            fill_line_q <= mem_data_i;
        end
    end

endmodule : icache_ctrl

// File: logic/icache_top.sv
// #########################################################################
// Direct-mapped instruction cache
// Sits between the warp fetcher and the instruction decoder
// #########################################################################

`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,

    // Fetcher
    input  logic         fe_valid_i,
    input  pc_t          fe_pc_i,
    input  fetch_mask_t  fe_fetch_mask_i,
    input  act_mask_t    fe_act_mask_i,
    input  wid_t         fe_warp_id_i,
    input  subwarp_id_t  fe_subwarp_id_i,
    output logic         ic_ready_o,

    // Backing memory
    input  logic         mem_ready_i,
    output logic         mem_req_o,
    output line_addr_t   mem_addr_o,
    input  logic         mem_valid_i,
    input  line_t        mem_data_i,

    // Decoder
    input  logic         dec_ready_i,
    output fetch_mask_t  ic_valid_o,
    output fetch_insts_t ic_inst_o,
    output pc_t          ic_pc_o,
    output fetch_mask_t  ic_fetch_mask_o,
    output act_mask_t    ic_act_mask_o,
    output wid_t         ic_warp_id_o,
    output subwarp_id_t  ic_subwarp_id_o
);

    // Shared memory port
    logic      ram_req, ram_we;
    line_sel_t ram_sel;
    tag_t      tag_wdata, tag_rdata;
    line_t     line_rdata;

    // Extractor inputs and results
    pc_t          req_pc;
    fetch_mask_t  req_fetch_mask;
    line_t        fill_line;
    fetch_mask_t  hit_valid, fill_valid;
    fetch_insts_t hit_inst, fill_inst;

    icache_ctrl i_ctrl (
        .clk_i            ( clk_i           ),
        .rst_ni           ( rst_ni          ),
        .flush_i          ( flush_i         ),
        .fe_valid_i       ( fe_valid_i      ),
        .fe_pc_i          ( fe_pc_i         ),
        .fe_fetch_mask_i  ( fe_fetch_mask_i ),
        .fe_act_mask_i    ( fe_act_mask_i   ),
        .fe_warp_id_i     ( fe_warp_id_i    ),
        .fe_subwarp_id_i  ( fe_subwarp_id_i ),
        .ic_ready_o       ( ic_ready_o      ),
        .mem_ready_i      ( mem_ready_i     ),
        .mem_req_o        ( mem_req_o       ),
        .mem_addr_o       ( mem_addr_o      ),
        .mem_valid_i      ( mem_valid_i     ),
        .mem_data_i       ( mem_data_i      ),
        .ram_req_o        ( ram_req         ),
        .ram_we_o         ( ram_we          ),
        .ram_sel_o        ( ram_sel         ),
        .tag_wdata_o      ( tag_wdata       ),
        .tag_rdata_i      ( tag_rdata       ),
        .req_pc_o         ( req_pc          ),
        .req_fetch_mask_o ( req_fetch_mask  ),
        .fill_line_o      ( fill_line       ),
        .hit_valid_i      ( hit_valid       ),
        .hit_inst_i       ( hit_inst        ),
        .fill_valid_i     ( fill_valid      ),
        .fill_inst_i      ( fill_inst       ),
        .dec_ready_i      ( dec_ready_i     ),
        .ic_valid_o       ( ic_valid_o      ),
        .ic_inst_o        ( ic_inst_o       ),
        .ic_pc_o          ( ic_pc_o         ),
        .ic_fetch_mask_o  ( ic_fetch_mask_o ),
        .ic_act_mask_o    ( ic_act_mask_o   ),
        .ic_warp_id_o     ( ic_warp_id_o    ),
        .ic_subwarp_id_o  ( ic_subwarp_id_o )
    );

    // Tag memory
    icache_sram #(
        .word_t   ( tag_t             ),
        .NumWords ( `ICACHE_NUM_LINES )
    ) i_tag_mem (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .req_i   ( ram_req   ),
        .we_i    ( ram_we    ),
        .addr_i  ( ram_sel   ),
        .wdata_i ( tag_wdata ),
        .rdata_o ( tag_rdata )
    );

    // Line memory, written straight from the memory response
    icache_sram #(
        .word_t   ( line_t            ),
        .NumWords ( `ICACHE_NUM_LINES )
    ) i_line_mem (
        .clk_i   ( clk_i      ),
        .rst_ni  ( rst_ni     ),
        .req_i   ( ram_req    ),
        .we_i    ( ram_we     ),
        .addr_i  ( ram_sel    ),
        .wdata_i ( mem_data_i ),
        .rdata_o ( line_rdata )
    );

    // Hit path
    icache_line_extract i_hit_extract (
        .line_i       ( line_rdata     ),
        .pc_i         ( req_pc         ),
        .fetch_mask_i ( req_fetch_mask ),
        .valid_o      ( hit_valid      ),
        .inst_o       ( hit_inst       )
    );

    // Refill path, reads the held line
    icache_line_extract i_fill_extract (
        .line_i       ( fill_line      ),
        .pc_i         ( req_pc         ),
        .fetch_mask_i ( req_fetch_mask ),
        .valid_o      ( fill_valid     ),
        .inst_o       ( fill_inst      )
    );

endmodule : icache_top

// File: verification/icache_tb.sv
// #########################################################################
// Instruction cache testbench
// Table-driven fetches checked against a reference model and memory model
// #########################################################################

`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int ClkPeriod = 4;
    localparam int NumRows   = 14;
    localparam int MemLines  = 1 << LineAddrBits;

    // Table row with stimulus and the expected hit or miss
    typedef struct packed {
        pc_t         pc;
        fetch_mask_t mask;
        wid_t        wid;
        subwarp_id_t swid;
        act_mask_t   act;
        logic        flush;
        logic [1:0]  stall;
        logic        exp_hit;
    } row_t;

    logic         clk_i;
    logic         rst_ni;
    logic         flush_i;
    logic         fe_valid_i;
    pc_t          fe_pc_i;
    fetch_mask_t  fe_fetch_mask_i;
    act_mask_t    fe_act_mask_i;
    wid_t         fe_warp_id_i;
    subwarp_id_t  fe_subwarp_id_i;
    logic         ic_ready_o;
    logic         mem_ready_i;
    logic         mem_req_o;
    line_addr_t   mem_addr_o;
    logic         mem_valid_i;
    line_t        mem_data_i;
    logic         dec_ready_i;
    fetch_mask_t  ic_valid_o;
    fetch_insts_t ic_inst_o;
    pc_t          ic_pc_o;
    fetch_mask_t  ic_fetch_mask_o;
    act_mask_t    ic_act_mask_o;
    wid_t         ic_warp_id_o;
    subwarp_id_t  ic_subwarp_id_o;

    // Backing memory contents and the addresses it was asked for
    line_t        mem_lines [MemLines];
    line_addr_t   req_addrs [$];
    logic [31:0]  rng_state;

    // Reference copy of the cache directory
    logic [`ICACHE_NUM_LINES-1:0] ref_valid;
    tag_t                         ref_tag [`ICACHE_NUM_LINES];

    row_t rows [NumRows];
    int   row_count;

    icache_top dut (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .flush_i         ( flush_i         ),
        .fe_valid_i      ( fe_valid_i      ),
        .fe_pc_i         ( fe_pc_i         ),
        .fe_fetch_mask_i ( fe_fetch_mask_i ),
        .fe_act_mask_i   ( fe_act_mask_i   ),
        .fe_warp_id_i    ( fe_warp_id_i    ),
        .fe_subwarp_id_i ( fe_subwarp_id_i ),
        .ic_ready_o      ( ic_ready_o      ),
        .mem_ready_i     ( mem_ready_i     ),
        .mem_req_o       ( mem_req_o       ),
        .mem_addr_o      ( mem_addr_o      ),
        .mem_valid_i     ( mem_valid_i     ),
        .mem_data_i      ( mem_data_i      ),
        .dec_ready_i     ( dec_ready_i     ),
        .ic_valid_o      ( ic_valid_o      ),
        .ic_inst_o       ( ic_inst_o       ),
        .ic_pc_o         ( ic_pc_o         ),
        .ic_fetch_mask_o ( ic_fetch_mask_o ),
        .ic_act_mask_o   ( ic_act_mask_o   ),
        .ic_warp_id_o    ( ic_warp_id_o    ),
        .ic_subwarp_id_o ( ic_subwarp_id_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #(ClkPeriod / 2) clk_i = ~clk_i;
    end

    // #########################################################################
    // Helpers
    // #########################################################################

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic fail_run();
        $display("Testbench failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_insts(input string name, input fetch_insts_t got,
                               input fetch_insts_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_mask(input string name, input fetch_mask_t got,
                              input fetch_mask_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_line_addr(input string name, input line_addr_t got,
                                   input line_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_act(input string name, input act_mask_t got, input act_mask_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_wid(input string name, input wid_t got, input wid_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_subwarp(input string name, input subwarp_id_t got,
                                 input subwarp_id_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    // All decoder outputs against the row and the predicted slots
    task automatic check_outputs(input row_t row, input fetch_mask_t exp_valid,
                                 input fetch_insts_t exp_inst);
        check_mask("ic_valid_o", ic_valid_o, exp_valid);
        check_insts("ic_inst_o", ic_inst_o, exp_inst);
        check_pc("ic_pc_o", ic_pc_o, row.pc);
        check_mask("ic_fetch_mask_o", ic_fetch_mask_o, row.mask);
        check_act("ic_act_mask_o", ic_act_mask_o, row.act);
        check_wid("ic_warp_id_o", ic_warp_id_o, row.wid);
        check_subwarp("ic_subwarp_id_o", ic_subwarp_id_o, row.swid);
    endtask

    // Hit or miss, slot valids and instructions for one fetch
    task automatic predict(input pc_t pc, input fetch_mask_t mask, output logic hit,
                           output fetch_mask_t valid, output fetch_insts_t insts);
        line_addr_t laddr;
        line_sel_t  sel;
        tag_t       tag;
        int         off;
        line_t      line;
        laddr = line_addr_t'(pc >> `ICACHE_LINE_IDX_BITS);
        sel   = line_sel_t'(laddr);
        tag   = tag_t'(laddr >> LineSelBits);
        off   = int'(pc) % LineInsts;
        line  = mem_lines[laddr];
        hit   = ref_valid[sel] && (ref_tag[sel] == tag);
        valid = '0;
        insts = '0;
        // Slots past the line end stay empty
        for (int k = 0; k < `ICACHE_FETCH_WIDTH; k++) begin
            if (off + k < LineInsts) begin
                valid[k] = mask[k];
                insts[k] = line[off + k];
            end
        end
    endtask

    task automatic refill_reference(input pc_t pc);
        line_addr_t laddr;
        laddr = line_addr_t'(pc >> `ICACHE_LINE_IDX_BITS);
        ref_valid[line_sel_t'(laddr)] = 1'b1;
        ref_tag[line_sel_t'(laddr)]   = tag_t'(laddr >> LineSelBits);
    endtask

    task automatic add_row(input pc_t pc, input fetch_mask_t mask, input wid_t wid,
                           input subwarp_id_t swid, input act_mask_t act,
                           input logic flush, input int stall, input logic exp_hit);
        row_t row;
        row.pc      = pc;
        row.mask    = mask;
        row.wid     = wid;
        row.swid    = swid;
        row.act     = act;
        row.flush   = flush;
        row.stall   = 2'(stall);
        row.exp_hit = exp_hit;
        rows[row_count] = row;
        row_count++;
    endtask

    // #########################################################################
    // Stimulus table
    // #########################################################################

    task automatic load_table();
        // pc, mask, warp, subwarp, active mask, flush, stall, hit
        add_row(8'h10, 2'b11, 3'd0, 5'd1,  32'hFFFF_FFFF, 1'b0, 0, 1'b0);
        add_row(8'h10, 2'b11, 3'd1, 5'd2,  32'h0000_FFFF, 1'b0, 0, 1'b1);
        // Offset 3 leaves room for slot 0 only
        add_row(8'h13, 2'b11, 3'd2, 5'd3,  32'h8000_0001, 1'b0, 0, 1'b1);
        add_row(8'h11, 2'b01, 3'd3, 5'd4,  32'h00FF_0000, 1'b0, 1, 1'b1);
        // Same index with different tags
        add_row(8'h30, 2'b11, 3'd4, 5'd5,  32'h1234_5678, 1'b0, 0, 1'b0);
        add_row(8'h10, 2'b11, 3'd5, 5'd6,  32'hFFFF_0000, 1'b0, 0, 1'b0);
        add_row(8'h30, 2'b01, 3'd6, 5'd7,  32'h0F0F_0F0F, 1'b0, 0, 1'b0);
        // Decoder stalls on refill and on hit
        add_row(8'h24, 2'b11, 3'd7, 5'd8,  32'hAAAA_5555, 1'b0, 3, 1'b0);
        add_row(8'h26, 2'b11, 3'd0, 5'd9,  32'h5555_AAAA, 1'b0, 2, 1'b1);
        // Flush drops the resident line
        add_row(8'h26, 2'b11, 3'd1, 5'd10, 32'hDEAD_BEEF, 1'b1, 1, 1'b0);
        add_row(8'h12, 2'b11, 3'd2, 5'd11, 32'h0000_0001, 1'b0, 0, 1'b0);
        add_row(8'h12, 2'b01, 3'd3, 5'd12, 32'h8000_0000, 1'b0, 0, 1'b1);
        add_row(8'hFF, 2'b11, 3'd4, 5'd31, 32'hC3C3_C3C3, 1'b0, 1, 1'b0);
        add_row(8'hFD, 2'b11, 3'd5, 5'd0,  32'h3C3C_3C3C, 1'b0, 0, 1'b1);
    endtask

    // #########################################################################
    // Backing memory model
    // #########################################################################

    initial begin : memory_model
        int unsigned grant_wait;
        int unsigned resp_wait;
        line_addr_t  addr;
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                grant_wait = next_random() % 4;
                repeat (grant_wait) @(negedge clk_i);
                addr        = mem_addr_o;
                mem_ready_i = 1'b1;
                req_addrs.push_back(addr);
                @(negedge clk_i);
                mem_ready_i = 1'b0;
                // Response 1 to 4 cycles after the grant
                resp_wait = next_random() % 4;
                repeat (resp_wait) @(negedge clk_i);
                mem_data_i  = mem_lines[addr];
                mem_valid_i = 1'b1;
                @(negedge clk_i);
                mem_valid_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(NumRows * 20 * ClkPeriod + 4 * ClkPeriod);
        $display("Timeout: the table rows did not all complete in time");
        fail_run();
    end

    // #########################################################################
    // Main sequence
    // #########################################################################

    initial begin : stimulus
        row_t         row;
        logic         exp_hit;
        fetch_mask_t  exp_valid;
        fetch_insts_t exp_inst;
        int unsigned  req_before;
        int unsigned  latency;
        logic         accepted;

        rst_ni          = 1'b0;
        flush_i         = 1'b0;
        fe_valid_i      = 1'b0;
        fe_pc_i         = '0;
        fe_fetch_mask_i = '0;
        fe_act_mask_i   = '0;
        fe_warp_id_i    = '0;
        fe_subwarp_id_i = '0;
        mem_ready_i     = 1'b0;
        mem_valid_i     = 1'b0;
        mem_data_i      = '0;
        dec_ready_i     = 1'b0;
        ref_valid       = '0;
        row_count       = 0;

        rng_state = 32'h4ddb5594;
        for (int i = 0; i < MemLines; i++) begin
            mem_lines[i] = line_t'(next_random());
        end
        load_table();

        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        check_mask("ic_valid_o", ic_valid_o, '0);
        if (!ic_ready_o || mem_req_o) begin
            $display("After reset the cache is not idle with ready high and no memory request");
            fail_run();
        end
        @(negedge clk_i);

        for (int r = 0; r < NumRows; r++) begin
            row = rows[r];
            if (row.flush) begin
                flush_i = 1'b1;
                @(negedge clk_i);
                flush_i   = 1'b0;
                ref_valid = '0;
            end
            predict(row.pc, row.mask, exp_hit, exp_valid, exp_inst);
            if (exp_hit !== row.exp_hit) begin
                $display("Row %0d: table and reference model disagree on hit or miss", r);
                fail_run();
            end
            req_before = req_addrs.size();

            fe_valid_i      = 1'b1;
            fe_pc_i         = row.pc;
            fe_fetch_mask_i = row.mask;
            fe_act_mask_i   = row.act;
            fe_warp_id_i    = row.wid;
            fe_subwarp_id_i = row.swid;
            dec_ready_i     = (row.stall == 0);

            // Ready sampled mid-cycle and taken at the next rising edge
            accepted = 1'b0;
            while (!accepted) begin
                #1;
                accepted = ic_ready_o;
                @(negedge clk_i);
            end
            // Scramble the inputs so held metadata is what gets checked
            fe_valid_i      = 1'b0;
            fe_pc_i         = ~row.pc;
            fe_fetch_mask_i = ~row.mask;
            fe_act_mask_i   = ~row.act;
            fe_warp_id_i    = ~row.wid;
            fe_subwarp_id_i = ~row.swid;

            latency = 1;
            #1;
            while (ic_valid_o == '0) begin
                @(negedge clk_i);
                #1;
                latency++;
            end
            if (exp_hit && latency != 1) begin
                $display("CHECK FAILED at %0t: hit latency is %0d, expected 1", $time, latency);
                fail_run();
            end
            check_outputs(row, exp_valid, exp_inst);

            // Outputs hold while the decoder stalls
            for (int s = 0; s < row.stall; s++) begin
                @(negedge clk_i);
                if (s == row.stall - 1) begin
                    dec_ready_i = 1'b1;
                end
                #1;
                check_outputs(row, exp_valid, exp_inst);
            end
            @(negedge clk_i);
            dec_ready_i = 1'b0;

            // One line request per miss and none per hit
            if (req_addrs.size() != req_before + (exp_hit ? 0 : 1)) begin
                $display("CHECK FAILED at %0t: memory request count is %0d, expected %0d",
                         $time, req_addrs.size() - req_before, exp_hit ? 0 : 1);
                fail_run();
            end
            if (!exp_hit) begin
                check_line_addr("mem_addr_o", req_addrs[req_addrs.size() - 1],
                                line_addr_t'(row.pc >> `ICACHE_LINE_IDX_BITS));
                refill_reference(row.pc);
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule : icache_tb

// File: flist.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_sram.sv
logic/icache_line_extract.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verification/icache_tb.sv
